// ==== nts_dispatcher.f ====
verilog/nts_buf_pkg.sv
verilog/nts_api_pkg.sv
verilog/nts_rx_aligner.sv
verilog/nts_frame_bram.sv
verilog/nts_frame_buffer.sv
verilog/nts_api_regs.sv
verilog/nts_dispatcher.sv
dv/tb_clock_gen.sv
dv/nts_dispatcher_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dispatcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f nts_dispatcher.f --top-module nts_dispatcher_tb

out=$(./obj_dir/Vnts_dispatcher_tb)
echo "$out"
echo "$out" | grep -q "^Simulation passed$"

// ==== dv/nts_dispatcher_tb.sv ====
// Banks hold 16 words here and all checks sample on the falling clock edge
`timescale 1ns/1ns
module nts_dispatcher_tb;

  localparam int ADDR_W      = 4;
  localparam int LEN_RT      = 5;
  localparam int LEN_BAD     = 4;
  localparam int LEN_A       = 3;
  localparam int LEN_B       = 7;
  localparam int LEN_OVF     = 18;  // Two words past a bank
  localparam int CYCLE_LIMIT = 4 * (LEN_RT + LEN_BAD + LEN_A + LEN_B + LEN_OVF) + 200;

  logic              clk;
  logic              areset;
  logic [7:0]        rx_keep;
  logic [63:0]       rx_data;
  logic              rx_good;
  logic              rx_bad;
  logic              pkt_avail;
  logic              discard;
  logic [ADDR_W-1:0] disp_cnt;
  logic [7:0]        disp_keep;
  logic              fifo_empty;
  logic              rd_start;
  logic              rd_valid;
  logic [63:0]       rd_data;
  logic              api_cs;
  logic              api_we;
  logic [11:0]       api_addr;
  logic [31:0]       api_wdata;
  logic [31:0]       api_rdata;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  logic [63:0] exp_words [8][16];
  int          exp_len [8];
  logic [7:0]  exp_keep [8];
  int          wr_frame = 0;    // Next slot for a complete good frame
  int          rd_frame = 0;    // Slot of the frame being offered
  int          rd_idx = 0;      // Words seen in the current burst
  int          since_start = 0;
  logic [63:0] m_frames = '0;
  logic [63:0] m_good = '0;
  logic [63:0] m_bad = '0;
  logic [63:0] m_bytes = '0;
  logic [63:0] m_disp = '0;
  logic [63:0] m_err = '0;
  logic        chk_rd = 1'b0;
  logic [31:0] exp_rd = '0;
  logic        read_active = 1'b0;
  logic        idle_after_reset = 1'b1;
  logic [31:0] lfsr = 32'h61d7d237;
  int          err_cnt = 0;
  int          err_mark = 0;
  int          test_cnt = 0;
  int          cyc = 0;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clk (.o_clk(clk), .o_areset(areset));

  nts_dispatcher #(
    .ADDR_WIDTH(ADDR_W)
  ) u_dut (
    .i_clk(clk),
    .i_areset(areset),
    .i_rx_data_valid(rx_keep),
    .i_rx_data(rx_data),
    .i_rx_bad_frame(rx_bad),
    .i_rx_good_frame(rx_good),
    .o_dispatch_packet_available(pkt_avail),
    .i_dispatch_packet_read_discard(discard),
    .o_dispatch_counter(disp_cnt),
    .o_dispatch_data_valid(disp_keep),
    .o_dispatch_fifo_empty(fifo_empty),
    .i_dispatch_fifo_rd_start(rd_start),
    .o_dispatch_fifo_rd_valid(rd_valid),
    .o_dispatch_fifo_rd_data(rd_data),
    .i_api_cs(api_cs),
    .i_api_we(api_we),
    .i_api_address(api_addr),
    .i_api_write_data(api_wdata),
    .o_api_read_data(api_rdata)
  );

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    $display("FAIL %0t ns %s expected %h got %h", $time, name, exp_v, got_v);
    err_cnt++;
  endtask

  task automatic report_issue(input string msg);
    $display("Error at %0t ns, %s", $time, msg);
    err_cnt++;
  endtask

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (cyc > CYCLE_LIMIT)
    begin
      $display("Timeout, no result after %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(posedge clk)
  begin
    if (rd_start)
      since_start <= 0;  // Edge that samples the start
    else
      since_start <= since_start + 1;
  end

  // Counts valid words of earlier cycles, stable at the falling edge
  always @(posedge clk)
  begin
    if (rd_valid)
      rd_idx <= rd_idx + 1;
    else if (rd_start)
      rd_idx <= 0;
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_reg_read: assert property (@(negedge clk) disable iff (areset)
    chk_rd |-> api_rdata == exp_rd)
    else report_mismatch("o_api_read_data", 64'(exp_rd), 64'(api_rdata));

  a_reset_idle: assert property (@(negedge clk) disable iff (areset)
    idle_after_reset |-> (fifo_empty && !pkt_avail && !rd_valid))
    else report_issue("dispatch outputs are not idle after reset");

  a_offer_pending: assert property (@(negedge clk) disable iff (areset)
    pkt_avail |-> rd_frame < wr_frame)
    else report_issue("a frame was offered with no complete good frame pending");

  a_offer_counter: assert property (@(negedge clk) disable iff (areset)
    pkt_avail |-> disp_cnt == ADDR_W'(exp_len[rd_frame] - 1))
    else report_mismatch("o_dispatch_counter", 64'(exp_len[rd_frame] - 1), 64'(disp_cnt));

  a_offer_keep: assert property (@(negedge clk) disable iff (areset)
    pkt_avail |-> disp_keep == exp_keep[rd_frame])
    else report_mismatch("o_dispatch_data_valid", 64'(exp_keep[rd_frame]), 64'(disp_keep));

  a_first_word: assert property (@(negedge clk) disable iff (areset)
    (rd_valid && rd_idx == 0) |-> since_start == 3)
    else report_issue("first read word did not arrive on the third edge after start");

  a_burst_len: assert property (@(negedge clk) disable iff (areset)
    rd_valid |-> rd_idx < exp_len[rd_frame])
    else report_issue("read burst is longer than the frame");

  a_rd_data: assert property (@(negedge clk) disable iff (areset)
    rd_valid |-> rd_data == exp_words[rd_frame][rd_idx])
    else report_mismatch("o_dispatch_fifo_rd_data", exp_words[rd_frame][rd_idx], rd_data);

  a_burst_done: assert property (@(negedge clk) disable iff (areset)
    (read_active && fifo_empty) |-> rd_idx == exp_len[rd_frame])
    else report_issue("FIFO went empty before the whole frame was read");

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------
  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    api_cs    <= 1'b1;
    api_we    <= 1'b1;
    api_addr  <= addr;
    api_wdata <= data;
    @(posedge clk);
    api_cs <= 1'b0;
    api_we <= 1'b0;
  endtask

  task automatic reg_read(input logic [11:0] addr, input logic [31:0] value);
    @(posedge clk);
    api_cs   <= 1'b1;
    api_we   <= 1'b0;
    api_addr <= addr;
    exp_rd   <= value;
    chk_rd   <= 1'b1;
    @(posedge clk);
    api_cs <= 1'b0;
    chk_rd <= 1'b0;
  endtask

  // MSB read latches the LSB
  task automatic check_counter(input logic [11:0] msb_addr, input logic [63:0] value);
    reg_read(msb_addr, value[63:32]);
    reg_read(msb_addr + 12'h1, value[31:0]);
  endtask

  task automatic send_frame(input int n_words, input int k, input bit good);
    logic [63:0] w;
    logic [7:0]  keep;
    bit          offer;
    offer = good && (n_words <= (1 << ADDR_W));
    for (int i = 0; i < n_words; i++)
    begin
      rand_bits(64, w);
      keep = (i == n_words - 1) ? 8'((1 << k) - 1) : 8'hff;
      if (offer)
        exp_words[wr_frame][i] = (i == n_words - 1) ? (w << (8 * (8 - k))) : w;
      @(posedge clk);
      rx_keep <= keep;
      rx_data <= w;
      rx_good <= good && (i == n_words - 1);
      rx_bad  <= !good && (i == n_words - 1);
    end
    @(posedge clk);
    rx_keep <= '0;
    rx_data <= '0;
    rx_good <= 1'b0;
    rx_bad  <= 1'b0;
    m_frames = m_frames + 1;
    m_bytes  = m_bytes + 64'(8 * (n_words - 1) + k);
    if (good)
      m_good = m_good + 1;
    else
      m_bad = m_bad + 1;
    if (n_words > (1 << ADDR_W))
      m_err = m_err + 1;
    if (offer)
    begin
      exp_len[wr_frame]  = n_words;
      exp_keep[wr_frame] = keep;
      wr_frame           = wr_frame + 1;
    end
  endtask

  task automatic wait_offer();
    @(negedge clk);
    while (!pkt_avail)
      @(negedge clk);
  endtask

  task automatic read_frame();
    wait_offer();
    @(posedge clk);
    rd_start    <= 1'b1;
    read_active <= 1'b1;
    m_disp = m_disp + 1;
    @(posedge clk);
    rd_start <= 1'b0;
    @(negedge clk);
    while (!fifo_empty)
      @(negedge clk);
    @(posedge clk);
    discard     <= 1'b1;  // Frees the bank
    read_active <= 1'b0;
    rd_frame = rd_frame + 1;
    @(posedge clk);
    discard <= 1'b0;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("Test %0d %s finished with %0d failed checks", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial
  begin
    logic [63:0] v;
    rx_keep   = '0;
    rx_data   = '0;
    rx_good   = 1'b0;
    rx_bad    = 1'b0;
    discard   = 1'b0;
    rd_start  = 1'b0;
    api_cs    = 1'b0;
    api_we    = 1'b0;
    api_addr  = '0;
    api_wdata = '0;
    @(negedge areset);
    repeat (2) @(posedge clk);

    reg_read(12'h000, "NTS-");
    reg_read(12'h001, "DISP");
    reg_read(12'h002, "0.02");
    rand_bits(32, v);
    reg_write(12'h003, v[31:0]);
    reg_read(12'h003, v[31:0]);
    end_test("identity and scratch");

    idle_after_reset = 1'b0;
    send_frame(LEN_RT, 3, 1'b1);
    read_frame();
    end_test("frame round trip");

    send_frame(LEN_BAD, 6, 1'b0);
    repeat (4) @(posedge clk);  // Room for a wrong offer
    check_counter(12'h024, m_bad);
    end_test("bad frame abort");

    send_frame(LEN_A, 8, 1'b1);
    wait_offer();
    send_frame(LEN_B, 1, 1'b1);  // Held behind the first
    read_frame();
    read_frame();
    end_test("ping-pong back-pressure");

    send_frame(LEN_OVF, 8, 1'b1);
    repeat (4) @(posedge clk);
    check_counter(12'h028, m_err);
    end_test("overflow");

    check_counter(12'h020, m_frames);
    check_counter(12'h022, m_good);
    check_counter(12'h024, m_bad);
    check_counter(12'h00a, m_bytes);
    check_counter(12'h026, m_disp);
    check_counter(12'h028, m_err);
    end_test("counters");

    $display("Tests run %0d, failed checks %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== dv/tb_clock_gen.sv ====
// Clock runs from time 0, reset is released by a rising edge after RESET_CYCLES edges
`timescale 1ns/1ns
module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_areset
);

  initial
  begin
    o_clk    = 1'b0;
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_areset <= 1'b0;
  end

  always #(PERIOD_NS / 2) o_clk = ~o_clk;  // 50 percent duty

endmodule

// ==== verilog/nts_dispatcher.sv ====
// ADDR_WIDTH sets the words per bank, a longer frame is counted as an error and not offered
`timescale 1ns/1ns
module nts_dispatcher #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                               i_clk,
  input  logic                               i_areset,
  input  logic [nts_buf_pkg::KEEP_W-1:0]     i_rx_data_valid,
  input  logic [nts_buf_pkg::WORD_W-1:0]     i_rx_data,
  input  logic                               i_rx_bad_frame,
  input  logic                               i_rx_good_frame,
  output logic                               o_dispatch_packet_available,
  input  logic                               i_dispatch_packet_read_discard,
  output logic [ADDR_WIDTH-1:0]              o_dispatch_counter,
  output logic [nts_buf_pkg::KEEP_W-1:0]     o_dispatch_data_valid,
  output logic                               o_dispatch_fifo_empty,
  input  logic                               i_dispatch_fifo_rd_start,
  output logic                               o_dispatch_fifo_rd_valid,
  output logic [nts_buf_pkg::WORD_W-1:0]     o_dispatch_fifo_rd_data,
  input  logic                               i_api_cs,
  input  logic                               i_api_we,
  input  logic [nts_api_pkg::API_ADDR_W-1:0] i_api_address,
  input  logic [nts_api_pkg::API_DATA_W-1:0] i_api_write_data,
  output logic [nts_api_pkg::API_DATA_W-1:0] o_api_read_data
);
  import nts_buf_pkg::*;

  logic                  sof;
  logic [WORD_W-1:0]     rx_word;     // Last word realigned
  logic [BYTE_CNT_W-1:0] rx_bytes;
  logic                  buf_error;
  buf_state_e            bank_state0;
  buf_state_e            bank_state1;
  logic                  current_bank;

  nts_rx_aligner u_aligner (
    .i_clk(i_clk),
    .i_areset(i_areset),
    .i_rx_data_valid(i_rx_data_valid),
    .i_rx_data(i_rx_data),
    .o_sof(sof),
    .o_word(rx_word),
    .o_bytes(rx_bytes)
  );

  nts_frame_buffer #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_buffer (
    .i_clk(i_clk),
    .i_areset(i_areset),
    .i_sof(sof),
    .i_word(rx_word),
    .i_keep(i_rx_data_valid),
    .i_rx_good_frame(i_rx_good_frame),
    .i_rx_bad_frame(i_rx_bad_frame),
    .i_dispatch_packet_read_discard(i_dispatch_packet_read_discard),
    .i_dispatch_fifo_rd_start(i_dispatch_fifo_rd_start),
    .o_dispatch_packet_available(o_dispatch_packet_available),
    .o_dispatch_counter(o_dispatch_counter),
    .o_dispatch_data_valid(o_dispatch_data_valid),
    .o_dispatch_fifo_empty(o_dispatch_fifo_empty),
    .o_dispatch_fifo_rd_valid(o_dispatch_fifo_rd_valid),
    .o_dispatch_fifo_rd_data(o_dispatch_fifo_rd_data),
    .o_error(buf_error),
    .o_bank_state0(bank_state0),
    .o_bank_state1(bank_state1),
    .o_current_bank(current_bank)
  );

  nts_api_regs u_regs (
    .i_clk(i_clk),
    .i_areset(i_areset),
    .i_sof(sof),
    .i_bytes(rx_bytes),
    .i_rx_good_frame(i_rx_good_frame),
    .i_rx_bad_frame(i_rx_bad_frame),
    .i_dispatch_fifo_rd_start(i_dispatch_fifo_rd_start),
    .i_error(buf_error),
    .i_bank_state0(bank_state0),
    .i_bank_state1(bank_state1),
    .i_current_bank(current_bank),
    .i_api_cs(i_api_cs),
    .i_api_we(i_api_we),
    .i_api_address(i_api_address),
    .i_api_write_data(i_api_write_data),
    .o_api_read_data(o_api_read_data)
  );

endmodule

// ==== verilog/nts_api_regs.sv ====
// Reads are combinational, reading a counter MSB latches its LSB for the following LSB read
`timescale 1ns/1ns
module nts_api_regs (
  input  logic                                i_clk,
  input  logic                                i_areset,
  input  logic                                i_sof,
  input  logic [nts_buf_pkg::BYTE_CNT_W-1:0]  i_bytes,
  input  logic                                i_rx_good_frame,
  input  logic                                i_rx_bad_frame,
  input  logic                                i_dispatch_fifo_rd_start,
  input  logic                                i_error,
  input  nts_buf_pkg::buf_state_e             i_bank_state0,
  input  nts_buf_pkg::buf_state_e             i_bank_state1,
  input  logic                                i_current_bank,
  input  logic                                i_api_cs,
  input  logic                                i_api_we,
  input  logic [nts_api_pkg::API_ADDR_W-1:0]  i_api_address,
  input  logic [nts_api_pkg::API_DATA_W-1:0]  i_api_write_data,
  output logic [nts_api_pkg::API_DATA_W-1:0]  o_api_read_data
);
  import nts_api_pkg::*;

  localparam int NUM_CNT = 6;

  // Counter order is frames, good, bad, bytes, dispatched, error
  localparam logic [API_ADDR_W-1:0] MSB_ADDR [NUM_CNT] = '{
    ADDR_CNT_FRAMES_MSB, ADDR_CNT_GOOD_MSB, ADDR_CNT_BAD_MSB,
    ADDR_BYTES_RX_MSB, ADDR_CNT_DISPATCHED_MSB, ADDR_CNT_ERROR_MSB};
  localparam logic [API_ADDR_W-1:0] LSB_ADDR [NUM_CNT] = '{
    ADDR_CNT_FRAMES_LSB, ADDR_CNT_GOOD_LSB, ADDR_CNT_BAD_LSB,
    ADDR_BYTES_RX_LSB, ADDR_CNT_DISPATCHED_LSB, ADDR_CNT_ERROR_LSB};

  logic [CNT_W-1:0]      cnt_reg [NUM_CNT];
  logic [API_DATA_W-1:0] lsb_reg [NUM_CNT];
  logic [CNT_W-1:0]      inc [NUM_CNT];
  logic [NUM_CNT-1:0]    latch;
  logic [API_DATA_W-1:0] scratch_reg;

  always_comb
  begin
    inc[0] = CNT_W'(i_sof);
    inc[1] = CNT_W'(i_rx_good_frame);
    inc[2] = CNT_W'(i_rx_bad_frame);
    inc[3] = CNT_W'(i_bytes);
    inc[4] = CNT_W'(i_dispatch_fifo_rd_start);
    inc[5] = CNT_W'(i_error);
  end

  // ------------------------------------------------------------
  // Read decode
  // ------------------------------------------------------------
  always_comb
  begin
    o_api_read_data = '0;
    latch           = '0;
    if (i_api_cs && !i_api_we)
    begin
      case (i_api_address)
        ADDR_NAME0:   o_api_read_data = CORE_NAME[63:32];
        ADDR_NAME1:   o_api_read_data = CORE_NAME[31:0];
        ADDR_VERSION: o_api_read_data = CORE_VERSION;
        ADDR_DUMMY:   o_api_read_data = scratch_reg;
        ADDR_STATES_INSPECT:
          o_api_read_data = {15'h0, i_current_bank, 4'h0, i_bank_state0, 4'h0, i_bank_state1};
        default: ;
      endcase
      for (int c = 0; c < NUM_CNT; c++)
      begin
        if (i_api_address == MSB_ADDR[c])
        begin
          o_api_read_data = cnt_reg[c][CNT_W-1:API_DATA_W];
          latch[c]        = 1'b1;
        end
        if (i_api_address == LSB_ADDR[c])
          o_api_read_data = lsb_reg[c];
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      scratch_reg <= '0;
      for (int c = 0; c < NUM_CNT; c++)
      begin
        cnt_reg[c] <= '0;
        lsb_reg[c] <= '0;
      end
    end
    else
    begin
      if (i_api_cs && i_api_we && i_api_address == ADDR_DUMMY)
        scratch_reg <= i_api_write_data;
      for (int c = 0; c < NUM_CNT; c++)
      begin
        cnt_reg[c] <= cnt_reg[c] + inc[c];
        if (latch[c])
          lsb_reg[c] <= cnt_reg[c][API_DATA_W-1:0];  // Snapshot with the MSB read
      end
    end
  end

  // MSB then LSB reads only pair up if counters only move forward
  for (genvar c = 0; c < NUM_CNT; c++)
  begin : g_mono
    a_no_decrease: assert property (@(posedge i_clk) disable iff (i_areset)
      cnt_reg[c] >= $past(cnt_reg[c]));
  end

endmodule

// ==== verilog/nts_frame_buffer.sv ====
// A bank receives while the other is offered and frames arriving when both are held are lost
`timescale 1ns/1ns
module nts_frame_buffer #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  logic                           i_sof,
  input  logic [nts_buf_pkg::WORD_W-1:0] i_word,
  input  logic [nts_buf_pkg::KEEP_W-1:0] i_keep,
  input  logic                           i_rx_good_frame,
  input  logic                           i_rx_bad_frame,
  input  logic                           i_dispatch_packet_read_discard,
  input  logic                           i_dispatch_fifo_rd_start,
  output logic                           o_dispatch_packet_available,
  output logic [ADDR_WIDTH-1:0]          o_dispatch_counter,
  output logic [nts_buf_pkg::KEEP_W-1:0] o_dispatch_data_valid,
  output logic                           o_dispatch_fifo_empty,
  output logic                           o_dispatch_fifo_rd_valid,
  output logic [nts_buf_pkg::WORD_W-1:0] o_dispatch_fifo_rd_data,
  output logic                           o_error,
  output nts_buf_pkg::buf_state_e        o_bank_state0,
  output nts_buf_pkg::buf_state_e        o_bank_state1,
  output logic                           o_current_bank
);
  import nts_buf_pkg::*;

  buf_state_e            state_reg [2];
  logic [ADDR_WIDTH-1:0] cnt_reg [2];   // Last written address
  logic [KEEP_W-1:0]     keep_reg [2];  // Keep of the last word
  logic                  cur_reg;       // Receive bank while the other one is read
  logic                  cur_new;

  buf_state_e            rx_state_new;
  logic [ADDR_WIDTH-1:0] rx_cnt_new;
  logic [KEEP_W-1:0]     rx_keep_new;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;

  buf_state_e            rd_state;
  buf_state_e            rd_state_new;
  logic [ADDR_WIDTH-1:0] rd_cnt;
  logic [ADDR_WIDTH-1:0] rd_addr_reg;
  logic [ADDR_WIDTH-1:0] rd_addr_new;
  logic                  empty_reg;
  logic                  empty_new;
  logic                  valid_reg;
  logic                  valid_new;
  logic [WORD_W-1:0]     data_reg;
  logic [WORD_W-1:0]     bank_rdata [2];

  // ------------------------------------------------------------
  // Memory banks
  // ------------------------------------------------------------
  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    logic bank_we;

    assign bank_we = wr_en && (cur_reg == 1'(b));

    nts_frame_bram #(
      .ADDR_WIDTH(ADDR_WIDTH)
    ) u_bram (
      .i_clk(i_clk),
      .i_write(bank_we),
      .i_addr(bank_we ? wr_addr : rd_addr_reg),
      .i_data(i_word),
      .o_data(bank_rdata[b])
    );
  end

  assign rd_state = state_reg[~cur_reg];
  assign rd_cnt   = cnt_reg[~cur_reg];

  assign o_dispatch_packet_available = (rd_state == out_init_0);
  assign o_dispatch_counter          = rd_cnt;
  assign o_dispatch_data_valid       = keep_reg[~cur_reg];
  assign o_dispatch_fifo_empty       = empty_reg;
  assign o_dispatch_fifo_rd_valid    = valid_reg;
  assign o_dispatch_fifo_rd_data     = data_reg;
  assign o_error        = (state_reg[0] == error) || (state_reg[1] == error);
  assign o_bank_state0  = state_reg[0];
  assign o_bank_state1  = state_reg[1];
  assign o_current_bank = cur_reg;

  // ------------------------------------------------------------
  // Receive writer on the current bank
  // ------------------------------------------------------------
  always_comb
  begin
    rx_state_new = state_reg[cur_reg];
    rx_cnt_new   = cnt_reg[cur_reg];
    rx_keep_new  = keep_reg[cur_reg];
    cur_new      = cur_reg;
    wr_en        = 1'b0;
    wr_addr      = cnt_reg[cur_reg] + 1'b1;
    if (i_rx_bad_frame)
    begin
      rx_state_new = empty;
      rx_cnt_new   = '0;
      rx_keep_new  = '0;
    end
    else
    begin
      case (state_reg[cur_reg])
        empty:
          if (i_sof)
          begin
            rx_state_new = has_data;
            rx_cnt_new   = '0;
            rx_keep_new  = '0;
            wr_en        = 1'b1;
            wr_addr      = '0;
            if (i_rx_good_frame)
            begin
              rx_keep_new  = i_keep;  // Single word frame
              rx_state_new = packet_received;
            end
          end
        has_data:
          if (i_keep != '0 && cnt_reg[cur_reg] == '1)
            rx_state_new = error;  // Frame longer than a bank
          else
          begin
            if (i_keep != '0)
            begin
              wr_en      = 1'b1;
              rx_cnt_new = wr_addr;
            end
            if (i_rx_good_frame)
            begin
              rx_keep_new  = i_keep;
              rx_state_new = packet_received;
            end
          end
        packet_received:
          if (rd_state == empty)
          begin
            rx_state_new = out_init_0;  // Offer it and swap
            cur_new      = ~cur_reg;
          end
        default:
          rx_state_new = empty;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Burst reader on the other bank
  // ------------------------------------------------------------
  always_comb
  begin
    rd_state_new = rd_state;
    rd_addr_new  = rd_addr_reg;
    empty_new    = empty_reg;
    valid_new    = 1'b0;
    if (i_dispatch_packet_read_discard)
    begin
      rd_state_new = empty;
      empty_new    = 1'b1;
    end
    else
    begin
      case (rd_state)
        out_init_0:
        begin
          rd_addr_new = '1;  // Wraps to word 0 in out_init_1
          empty_new   = 1'b0;
          if (i_dispatch_fifo_rd_start)
            rd_state_new = out_init_1;
        end
        out_init_1:
        begin
          rd_addr_new = rd_addr_reg + 1'b1;
          if (rd_addr_reg == '0)  // Word 0 now addressed
            rd_state_new = (rd_cnt == '0) ? out_fin_0 : out;
        end
        out:
        begin
          valid_new = 1'b1;
          if (rd_addr_reg == rd_cnt)
            rd_state_new = out_fin_0;
          else
            rd_addr_new = rd_addr_reg + 1'b1;
        end
        out_fin_0:
        begin
          valid_new    = 1'b1;  // Last word
          rd_state_new = out_fin_1;
        end
        out_fin_1:
          empty_new = 1'b1;  // Held until discard
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int b = 0; b < 2; b++)
      begin
        state_reg[b] <= empty;
        cnt_reg[b]   <= '0;
        keep_reg[b]  <= '0;
      end
      cur_reg     <= 1'b0;
      rd_addr_reg <= '0;
      empty_reg   <= 1'b1;
      valid_reg   <= 1'b0;
    end
    else
    begin
      state_reg[cur_reg]  <= rx_state_new;
      cnt_reg[cur_reg]    <= rx_cnt_new;
      keep_reg[cur_reg]   <= rx_keep_new;
      state_reg[~cur_reg] <= rd_state_new;
      cur_reg             <= cur_new;
      rd_addr_reg         <= rd_addr_new;
      empty_reg           <= empty_new;
      valid_reg           <= valid_new;
    end
  end

  always_ff @(posedge i_clk)
  begin
    data_reg <= bank_rdata[~cur_reg];
  end

  // Swap only happens into an empty reader bank
  a_one_reader: assert property (@(posedge i_clk) disable iff (i_areset)
    !((state_reg[0] inside {out_init_0, out_init_1, out, out_fin_0, out_fin_1}) &&
      (state_reg[1] inside {out_init_0, out_init_1, out, out_fin_0, out_fin_1})));

  // Registered valid still covers the last word in out_fin_1
  a_valid_window: assert property (@(posedge i_clk) disable iff (i_areset)
    o_dispatch_fifo_rd_valid |-> rd_state inside {out, out_fin_0, out_fin_1});

endmodule

// ==== verilog/nts_frame_bram.sv ====
// Registered read one clock after the address, contents are undefined until written
`timescale 1ns/1ns
module nts_frame_bram #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                           i_clk,
  input  logic                           i_write,
  input  logic [ADDR_WIDTH-1:0]          i_addr,
  input  logic [nts_buf_pkg::WORD_W-1:0] i_data,
  output logic [nts_buf_pkg::WORD_W-1:0] o_data
);
  import nts_buf_pkg::*;

  logic [WORD_W-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge i_clk)
  begin
    if (i_write)
      mem[i_addr] <= i_data;
    o_data <= mem[i_addr];  // Old word on a write
  end

endmodule

// ==== verilog/nts_rx_aligner.sv ====
// Keep masks must fill from byte 0 upward, any other pattern passes through and counts no bytes
`timescale 1ns/1ns
module nts_rx_aligner (
  input  logic                               i_clk,
  input  logic                               i_areset,
  input  logic [nts_buf_pkg::KEEP_W-1:0]     i_rx_data_valid,
  input  logic [nts_buf_pkg::WORD_W-1:0]     i_rx_data,
  output logic                               o_sof,
  output logic [nts_buf_pkg::WORD_W-1:0]     o_word,
  output logic [nts_buf_pkg::BYTE_CNT_W-1:0] o_bytes
);
  import nts_buf_pkg::*;

  logic [KEEP_W-1:0] prev_keep;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      prev_keep <= '1;  // Nonzero, no false start after reset
    else
      prev_keep <= i_rx_data_valid;
  end

  // Idle gap followed by a full word
  assign o_sof = (prev_keep == '0) && (i_rx_data_valid == '1);

  // ------------------------------------------------------------
  // Partial last word moves its bytes to the top
  // ------------------------------------------------------------
  always_comb
  begin
    o_word  = i_rx_data;  // Unexpected mask
    o_bytes = '0;
    if (i_rx_data_valid == '0)
      o_word = '0;
    for (int k = 1; k <= KEEP_W; k++)
    begin
      if (i_rx_data_valid == KEEP_W'((1 << k) - 1))
      begin
        o_word  = i_rx_data << (8 * (KEEP_W - k));
        o_bytes = BYTE_CNT_W'(k);
      end
    end
  end

  // MAC side contract, the buffer relies on it for the stored keep
  a_keep_contiguous: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_rx_data_valid & (i_rx_data_valid + 1'b1)) == '0);

endmodule

// ==== verilog/nts_api_pkg.sv ====
// Register map of the dispatcher, 32-bit data on a 12-bit word address, unmapped reads give 0
package nts_api_pkg;

  localparam int API_ADDR_W = 12;
  localparam int API_DATA_W = 32;
  localparam int CNT_W      = 64;  // Event counters, read as MSB then LSB

  // ------------------------------------------------------------
  // Addresses
  // ------------------------------------------------------------
  localparam logic [API_ADDR_W-1:0] ADDR_NAME0              = 'h0;
  localparam logic [API_ADDR_W-1:0] ADDR_NAME1              = 'h1;
  localparam logic [API_ADDR_W-1:0] ADDR_VERSION            = 'h2;
  localparam logic [API_ADDR_W-1:0] ADDR_DUMMY              = 'h3;  // Scratch
  localparam logic [API_ADDR_W-1:0] ADDR_STATES_INSPECT     = 'h5;
  localparam logic [API_ADDR_W-1:0] ADDR_BYTES_RX_MSB       = 'ha;
  localparam logic [API_ADDR_W-1:0] ADDR_BYTES_RX_LSB       = 'hb;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_FRAMES_MSB     = 'h20;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_FRAMES_LSB     = 'h21;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_GOOD_MSB       = 'h22;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_GOOD_LSB       = 'h23;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_BAD_MSB        = 'h24;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_BAD_LSB        = 'h25;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_DISPATCHED_MSB = 'h26;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_DISPATCHED_LSB = 'h27;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_ERROR_MSB      = 'h28;
  localparam logic [API_ADDR_W-1:0] ADDR_CNT_ERROR_LSB      = 'h29;

  // Identity, plain ASCII
  localparam logic [63:0] CORE_NAME    = "NTS-DISP";
  localparam logic [31:0] CORE_VERSION = "0.02";

endpackage

// ==== verilog/nts_buf_pkg.sv ====
// Frame buffer word format is 64-bit data with a byte-keep mask filled from bit 0 upward
package nts_buf_pkg;

  // ------------------------------------------------------------
  // Receive word format
  // ------------------------------------------------------------
  localparam int WORD_W     = 64;  // MAC data word
  localparam int KEEP_W     = 8;   // One keep bit per byte
  localparam int BYTE_CNT_W = 4;   // 0 to 8 bytes in a word

  // ------------------------------------------------------------
  // Bank life cycle, receive states then reader states
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    empty,
    has_data,
    packet_received,
    out_init_0,
    out_init_1,
    out,
    out_fin_0,
    out_fin_1,
    error
  } buf_state_e;

endpackage
